//--- rtl/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Frame timing
//////////////////////////////////////////////////////////////////////

// Baud ticks per serial bit
`define UART_OVERSAMPLE 16

// Width of the baud divisor register
`define UART_DIV_WIDTH 16

// Divisor loaded at reset, clk cycles per tick
`define UART_RESET_DIV 4

//////////////////////////////////////////////////////////////////////
// Receive buffering and register map
//////////////////////////////////////////////////////////////////////

// Entries in the receive FIFO, power of two
`define UART_FIFO_DEPTH 8

// Register addresses
`define UART_ADDR_DIV 2'd0
`define UART_ADDR_CTRL 2'd1
`define UART_ADDR_STATUS 2'd2
`define UART_ADDR_ERRCNT 2'd3

`endif

//--- rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

	//////////////////////////////////////////////////////////////////////
	// Data and address types
	//////////////////////////////////////////////////////////////////////

	// One serial data byte, LSB sent first
	typedef logic [7:0] uart_byte_t;

	// Index into the four-entry register map
	typedef logic [1:0] uart_reg_addr_t;

	//////////////////////////////////////////////////////////////////////
	// Receiver FSM
	//////////////////////////////////////////////////////////////////////

	// Gray-style encoding, one bit flips per step
	typedef enum logic [1:0]
	{
		// Line high, waiting for a falling edge
		RX_IDLE  = 2'b00,
		// Half bit until mid start bit
		RX_START = 2'b01,
		// Eight data samples
		RX_DATA  = 2'b11,
		// Stop bit check
		RX_STOP  = 2'b10
	} uart_rx_state_t;

endpackage

`default_nettype wire

//--- rtl/uart_cfg_if.sv
`default_nettype none

`include "uart_macros.svh"

interface uart_cfg_if;

	// Settings from the register block
	logic [`UART_DIV_WIDTH-1:0] divisor;
	logic rx_enable;
	logic tx_enable;

	// Event pulses back to the register block
	logic frame_error;
	logic overrun;

	// Register block owns the settings and counts the events
	modport regs (output divisor, output rx_enable, output tx_enable,
		input frame_error, input overrun);

	// Tick generator only needs the rate
	modport baud (input divisor);

	// Serial side, receiver reports bad stop bits
	modport rx (input rx_enable, input tx_enable, output frame_error);

	// FIFO reports dropped bytes
	modport fifo (output overrun);

endinterface

`default_nettype wire

//--- rtl/uart_baud_gen.sv
`default_nettype none

`include "uart_macros.svh"

module uart_baud_gen
(
	input  logic     clk,
	input  logic     reset,
	uart_cfg_if.baud cfg,
	output logic     tick
);

	logic [`UART_DIV_WIDTH-1:0] cnt;
	logic [`UART_DIV_WIDTH-1:0] div_q;
	logic [`UART_DIV_WIDTH-1:0] reload;

	// Divisor of 0 or 1 gives a tick every cycle
	always_comb
	begin
		reload = (cfg.divisor == '0) ? '0 : cfg.divisor - 1'b1;
	end

	// Down counter, tick when it hits zero
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt   <= `UART_DIV_WIDTH'(`UART_RESET_DIV - 1);
			div_q <= `UART_DIV_WIDTH'(`UART_RESET_DIV);
			tick  <= 1'b0;
		end
		else if (cfg.divisor != div_q)
		begin
			// New rate, restart the period right away
			div_q <= cfg.divisor;
			cnt   <= reload;
			tick  <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt  <= reload;
			tick <= 1'b1;
		end
		else
		begin
			cnt  <= cnt - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
`default_nettype none

`include "uart_macros.svh"

module uart_rx
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 tick,
	input  logic                 rx_line,
	uart_cfg_if.rx               cfg,
	output logic                 byte_valid,
	output uart_pkg::uart_byte_t byte_data
);

	import uart_pkg::*;

	// Last tick of half a bit and of a full bit
	localparam logic [3:0] HALF_LAST = 4'(`UART_OVERSAMPLE / 2 - 1);
	localparam logic [3:0] BIT_LAST  = 4'(`UART_OVERSAMPLE - 1);

	uart_rx_state_t state;
	logic [3:0] tick_cnt;
	logic [2:0] bit_idx;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	uart_byte_t shift_reg;

	//////////////////////////////////////////////////////////////////////
	// Line synchronizer
	//////////////////////////////////////////////////////////////////////

	// Two flops into clk domain, third one for edge detect
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rx_line;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state           <= RX_IDLE;
			tick_cnt        <= '0;
			bit_idx         <= '0;
			byte_valid      <= 1'b0;
			cfg.frame_error <= 1'b0;
		end
		else
		begin
			// Both reports are single-cycle pulses
			byte_valid      <= 1'b0;
			cfg.frame_error <= 1'b0;
			if (!cfg.rx_enable)
			begin
				state <= RX_IDLE;
			end
			else
			begin
				case (state)
					RX_IDLE:
					begin
						tick_cnt <= '0;
						bit_idx  <= '0;
						// High to low, a stuck-low line after a bad stop bit is ignored
						if (rx_prev && !rx_sync)
							state <= RX_START;
					end
					RX_START:
					begin
						if (tick)
						begin
							if (tick_cnt == HALF_LAST)
							begin
								tick_cnt <= '0;
								// Still low at mid bit, else a glitch
								state <= rx_sync ? RX_IDLE : RX_DATA;
							end
							else
								tick_cnt <= tick_cnt + 1'b1;
						end
					end
					RX_DATA:
					begin
						if (tick)
						begin
							if (tick_cnt == BIT_LAST)
							begin
								tick_cnt <= '0;
								bit_idx  <= bit_idx + 1'b1;
								if (bit_idx == 3'd7)
									state <= RX_STOP;
							end
							else
								tick_cnt <= tick_cnt + 1'b1;
						end
					end
					RX_STOP:
					begin
						if (tick)
						begin
							if (tick_cnt == BIT_LAST)
							begin
								tick_cnt <= '0;
								state    <= RX_IDLE;
								// Mid stop bit, 1 is good and 0 is a framing error
								if (rx_sync)
									byte_valid <= 1'b1;
								else
									cfg.frame_error <= 1'b1;
							end
							else
								tick_cnt <= tick_cnt + 1'b1;
						end
					end
					default:
						state <= RX_IDLE;
				endcase
			end
		end
	end

	// Data shift, LSB arrives first so shift right
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && tick && tick_cnt == BIT_LAST)
			shift_reg <= {rx_sync, shift_reg[7:1]};
	end

	assign byte_data = shift_reg;

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
`default_nettype none

`include "uart_macros.svh"

module uart_tx
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 tick,
	uart_cfg_if.rx               cfg,
	input  logic                 tx_valid,
	input  uart_pkg::uart_byte_t tx_data,
	output logic                 tx_busy,
	output logic                 tx_line
);

	localparam logic [3:0] BIT_LAST = 4'(`UART_OVERSAMPLE - 1);

	// Stop, 8 data bits, start
	localparam logic [3:0] FRAME_LAST = 4'd9;

	logic [9:0] frame;
	logic [3:0] tick_cnt;
	logic [3:0] bit_cnt;
	logic busy;
	logic accept;

	// Disabled transmitter looks busy to the host
	assign tx_busy = busy || !cfg.tx_enable;
	assign accept  = tx_valid && !tx_busy;

	//////////////////////////////////////////////////////////////////////
	// Serializer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			// All ones keeps the line idle high
			frame    <= '1;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			busy     <= 1'b0;
		end
		else if (accept)
		begin
			// Start bit goes out on bit 0 next cycle
			frame    <= {1'b1, tx_data, 1'b0};
			tick_cnt <= '0;
			bit_cnt  <= '0;
			busy     <= 1'b1;
		end
		else if (busy && tick)
		begin
			if (tick_cnt == BIT_LAST)
			begin
				// End of a bit time, shift in idle level
				tick_cnt <= '0;
				frame    <= {1'b1, frame[9:1]};
				bit_cnt  <= bit_cnt + 1'b1;
				if (bit_cnt == FRAME_LAST)
					busy <= 1'b0;
			end
			else
				tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// Line is just the low end of the frame
	assign tx_line = frame[0];

endmodule

`default_nettype wire

//--- rtl/uart_regs.sv
`default_nettype none

`include "uart_macros.svh"

module uart_regs
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     reg_write,
	input  uart_pkg::uart_reg_addr_t reg_addr,
	input  logic [15:0]              reg_wdata,
	output logic [15:0]              reg_rdata,
	uart_cfg_if.regs                 cfg
);

	logic [`UART_DIV_WIDTH-1:0] divisor;
	logic rx_en;
	logic tx_en;
	logic overrun_flag;
	logic [7:0] err_cnt;

	//////////////////////////////////////////////////////////////////////
	// Register writes and event capture
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divisor      <= `UART_DIV_WIDTH'(`UART_RESET_DIV);
			rx_en        <= 1'b1;
			tx_en        <= 1'b1;
			overrun_flag <= 1'b0;
			err_cnt      <= '0;
		end
		else
		begin
			if (reg_write && reg_addr == `UART_ADDR_DIV)
				divisor <= reg_wdata[`UART_DIV_WIDTH-1:0];
			if (reg_write && reg_addr == `UART_ADDR_CTRL)
			begin
				rx_en <= reg_wdata[0];
				tx_en <= reg_wdata[1];
			end
			// New overrun wins over a clear in the same cycle
			if (cfg.overrun)
				overrun_flag <= 1'b1;
			else if (reg_write && reg_addr == `UART_ADDR_STATUS && reg_wdata[0])
				overrun_flag <= 1'b0;
			// Any write clears, else count up to 255
			if (reg_write && reg_addr == `UART_ADDR_ERRCNT)
				err_cnt <= '0;
			else if (cfg.frame_error && err_cnt != 8'hff)
				err_cnt <= err_cnt + 1'b1;
		end
	end

	// Read mux, no wait state
	always_comb
	begin
		case (reg_addr)
			`UART_ADDR_DIV:    reg_rdata = 16'(divisor);
			`UART_ADDR_CTRL:   reg_rdata = {14'd0, tx_en, rx_en};
			`UART_ADDR_STATUS: reg_rdata = {15'd0, overrun_flag};
			default:           reg_rdata = {8'd0, err_cnt};
		endcase
	end

	assign cfg.divisor   = divisor;
	assign cfg.rx_enable = rx_en;
	assign cfg.tx_enable = tx_en;

endmodule

`default_nettype wire

//--- rtl/uart_rx_credit.sv
`default_nettype none

`include "uart_macros.svh"

module uart_rx_credit
(
	input  logic                 clk,
	input  logic                 reset,
	uart_cfg_if.fifo             cfg,
	input  logic                 byte_valid,
	input  uart_pkg::uart_byte_t byte_data,
	input  logic                 credit_return,
	output logic                 rx_valid,
	output uart_pkg::uart_byte_t rx_data
);

	import uart_pkg::*;

	localparam int AW = $clog2(`UART_FIFO_DEPTH);
	localparam int CW = AW + 1;
	localparam logic [CW-1:0] DEPTH = CW'(`UART_FIFO_DEPTH);

	uart_byte_t mem [`UART_FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic [CW-1:0] credits;
	logic push;
	logic pop;

	// Full FIFO drops the byte, pop needs both data and a credit
	assign push = byte_valid && count != DEPTH;
	assign pop  = credits != '0 && count != '0;

	//////////////////////////////////////////////////////////////////////
	// Pointers, fill level and credits
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			credits     <= '0;
			rx_valid    <= 1'b0;
			cfg.overrun <= 1'b0;
		end
		else
		begin
			// Pointers wrap on their own, depth is a power of two
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			// Grant and spend in one cycle cancel out
			if (credit_return && !pop && credits != DEPTH)
				credits <= credits + 1'b1;
			else if (pop && !credit_return)
				credits <= credits - 1'b1;
			rx_valid    <= pop;
			cfg.overrun <= byte_valid && !push;
		end
	end

	// Storage and output byte
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= byte_data;
		if (pop)
			rx_data <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

//--- rtl/uart_top.sv
`default_nettype none

module uart_top
(
	input  logic                     clk,
	input  logic                     reset,
	// Serial pins
	input  logic                     rx_line,
	output logic                     tx_line,
	// Register port
	input  logic                     reg_write,
	input  uart_pkg::uart_reg_addr_t reg_addr,
	input  logic [15:0]              reg_wdata,
	output logic [15:0]              reg_rdata,
	// Transmit handshake
	input  logic                     tx_valid,
	input  uart_pkg::uart_byte_t     tx_data,
	output logic                     tx_busy,
	// Credit-based receive handshake
	input  logic                     credit_return,
	output logic                     rx_valid,
	output uart_pkg::uart_byte_t     rx_data
);

	import uart_pkg::*;

	logic tick;
	logic byte_valid;
	uart_byte_t byte_data;

	// Settings out, error events back
	uart_cfg_if cfg ();

	//////////////////////////////////////////////////////////////////////
	// Control and timing
	//////////////////////////////////////////////////////////////////////

	uart_regs i_uart_regs (.clk(clk), .reset(reset), .reg_write(reg_write),
		.reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata), .cfg(cfg));

	// One tick shared by both directions
	uart_baud_gen i_uart_baud_gen (.clk(clk), .reset(reset), .cfg(cfg), .tick(tick));

	//////////////////////////////////////////////////////////////////////
	// Serial datapath
	//////////////////////////////////////////////////////////////////////

	uart_rx i_uart_rx (.clk(clk), .reset(reset), .tick(tick), .rx_line(rx_line),
		.cfg(cfg), .byte_valid(byte_valid), .byte_data(byte_data));

	uart_rx_credit i_uart_rx_credit (.clk(clk), .reset(reset), .cfg(cfg),
		.byte_valid(byte_valid), .byte_data(byte_data), .credit_return(credit_return),
		.rx_valid(rx_valid), .rx_data(rx_data));

	uart_tx i_uart_tx (.clk(clk), .reset(reset), .tick(tick), .cfg(cfg),
		.tx_valid(tx_valid), .tx_data(tx_data), .tx_busy(tx_busy), .tx_line(tx_line));

endmodule

`default_nettype wire

//--- verification/uart_tb.sv
`default_nettype none

`include "uart_macros.svh"

module uart_tb;

	import uart_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int NEW_DIV = 6;
	// Frames on either line over the whole run
	localparam int FRAME_COUNT = 22;
	// Eleven bit times per frame at the slowest divisor and twice over for margin
	localparam int WATCHDOG_TIME =
		2 * FRAME_COUNT * 11 * `UART_OVERSAMPLE * NEW_DIV * CLK_PERIOD;

	logic clk;
	logic reset;
	logic rx_line;
	logic tx_line;
	logic reg_write;
	uart_reg_addr_t reg_addr;
	logic [15:0] reg_wdata;
	logic [15:0] reg_rdata;
	logic tx_valid;
	uart_byte_t tx_data;
	logic tx_busy;
	logic credit_return;
	logic rx_valid;
	uart_byte_t rx_data;

	int cur_div;
	logic [31:0] lfsr;
	// Log of every byte seen on the receive handshake
	uart_byte_t rx_log [64];
	logic [5:0] rx_wr;
	logic [5:0] rx_rd;

	uart_top i_uart_top (.clk(clk), .reset(reset), .rx_line(rx_line), .tx_line(tx_line),
		.reg_write(reg_write), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata), .tx_valid(tx_valid), .tx_data(tx_data), .tx_busy(tx_busy),
		.credit_return(credit_return), .rx_valid(rx_valid), .rx_data(rx_data));

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Capture rx_valid pulses with the values from before this edge
	always @(posedge clk or posedge reset)
	begin
		if (reset)
			rx_wr <= '0;
		else if (rx_valid)
		begin
			rx_log[rx_wr] <= rx_data;
			rx_wr <= rx_wr + 6'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks and failure exit
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_byte(input string name, input uart_byte_t expected,
		input uart_byte_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_reg(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("[ERROR] t=%0t %s expected %b actual %b", $time, name, expected, actual);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers that return one unit after a rising edge
	//////////////////////////////////////////////////////////////////////

	// Galois step for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {1'b0, state[31:1]} ^ (state[0] ? 32'h80200003 : 32'h0);
	endfunction

	// One LFSR step per data bit
	task automatic next_rand_byte(output uart_byte_t value);
		value = '0;
		repeat (8)
		begin
			lfsr = lfsr_next(lfsr);
			value = {lfsr[0], value[7:1]};
		end
	endtask

	// Start, data LSB first, stop, then one idle bit
	task automatic send_frame(input uart_byte_t data, input logic stop_bit);
		logic [9:0] frame;
		frame = {stop_bit, data, 1'b0};
		repeat (10)
		begin
			rx_line = frame[0];
			frame = {1'b1, frame[9:1]};
			repeat (cur_div * `UART_OVERSAMPLE) @(posedge clk);
			#1;
		end
		rx_line = 1'b1;
		repeat (cur_div * `UART_OVERSAMPLE) @(posedge clk);
		#1;
	endtask

	// One credit per cycle of credit_return
	task automatic grant_credits(input int n);
		repeat (n)
		begin
			credit_return = 1'b1;
			@(posedge clk);
			#1;
		end
		credit_return = 1'b0;
	endtask

	task automatic expect_rx_byte(input uart_byte_t expected);
		int n;
		n = 0;
		while (rx_wr == rx_rd && n < 100)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (rx_wr == rx_rd)
		begin
			$display("Timed out waiting for a byte on rx_valid");
			abort_run();
		end
		check_byte("rx_data", expected, rx_log[rx_rd]);
		rx_rd = rx_rd + 6'd1;
	endtask

	// No pending byte after a quiet stretch
	task automatic expect_rx_quiet(input int cycles);
		repeat (cycles) @(posedge clk);
		#1;
		check_bit("rx_valid seen", 1'b0, rx_wr != rx_rd);
	endtask

	task automatic write_reg(input uart_reg_addr_t addr, input logic [15:0] data);
		reg_write = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
		@(posedge clk);
		#1;
		reg_write = 1'b0;
	endtask

	// Read mux is combinational
	task automatic check_reg_read(input string name, input uart_reg_addr_t addr,
		input logic [15:0] expected);
		reg_addr = addr;
		#1;
		check_reg(name, expected, reg_rdata);
		@(posedge clk);
		#1;
	endtask

	task automatic wait_tx_idle();
		int n;
		n = 0;
		while (tx_busy && n < 11 * `UART_OVERSAMPLE * cur_div + 50)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (tx_busy)
		begin
			$display("Timed out waiting for tx_busy to fall");
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	// One frame in, one credit, one byte out
	task automatic test_receive(input int count);
		uart_byte_t b;
		repeat (count)
		begin
			next_rand_byte(b);
			send_frame(b, 1'b1);
			grant_credits(1);
			expect_rx_byte(b);
		end
	endtask

	task automatic test_credit_gating();
		uart_byte_t sent [$];
		uart_byte_t b;
		repeat (3)
		begin
			next_rand_byte(b);
			sent.push_back(b);
			send_frame(b, 1'b1);
		end
		// Bytes parked in the FIFO
		expect_rx_quiet(1);
		check_bit("rx_valid", 1'b0, rx_valid);
		grant_credits(2);
		repeat (2)
		begin
			b = sent.pop_front();
			expect_rx_byte(b);
		end
		expect_rx_quiet(32);
		// Drain the last one
		grant_credits(1);
		b = sent.pop_front();
		expect_rx_byte(b);
	endtask

	task automatic test_overrun();
		uart_byte_t sent [$];
		uart_byte_t b;
		check_reg_read("STATUS", `UART_ADDR_STATUS, 16'h0000);
		repeat (`UART_FIFO_DEPTH + 1)
		begin
			next_rand_byte(b);
			sent.push_back(b);
			send_frame(b, 1'b1);
		end
		check_reg_read("STATUS", `UART_ADDR_STATUS, 16'h0001);
		grant_credits(`UART_FIFO_DEPTH);
		repeat (`UART_FIFO_DEPTH)
		begin
			b = sent.pop_front();
			expect_rx_byte(b);
		end
		// A spare credit must find the FIFO empty since the last byte was dropped
		grant_credits(1);
		expect_rx_quiet(32);
		write_reg(`UART_ADDR_STATUS, 16'h0001);
		check_reg_read("STATUS", `UART_ADDR_STATUS, 16'h0000);
	endtask

	task automatic test_framing_error();
		uart_byte_t b;
		check_reg_read("ERRCNT", `UART_ADDR_ERRCNT, 16'h0000);
		next_rand_byte(b);
		send_frame(b, 1'b0);
		grant_credits(1);
		expect_rx_quiet(32);
		check_reg_read("ERRCNT", `UART_ADDR_ERRCNT, 16'h0001);
	endtask

	task automatic test_transmit(input int count);
		uart_byte_t b;
		uart_byte_t got;
		repeat (count)
		begin
			next_rand_byte(b);
			wait_tx_idle();
			tx_valid = 1'b1;
			tx_data = b;
			@(posedge clk);
			#1;
			tx_valid = 1'b0;
			check_bit("tx_busy", 1'b1, tx_busy);
			// Middle of the start bit, then one bit time per sample
			repeat (8 * cur_div) @(posedge clk);
			#1;
			check_bit("tx_line start", 1'b0, tx_line);
			got = '0;
			repeat (8)
			begin
				repeat (`UART_OVERSAMPLE * cur_div) @(posedge clk);
				#1;
				got = {tx_line, got[7:1]};
			end
			check_byte("tx_line data", b, got);
			repeat (`UART_OVERSAMPLE * cur_div) @(posedge clk);
			#1;
			check_bit("tx_line stop", 1'b1, tx_line);
			wait_tx_idle();
			check_bit("tx_line idle", 1'b1, tx_line);
		end
	endtask

	task automatic test_divisor_change();
		write_reg(`UART_ADDR_DIV, 16'(NEW_DIV));
		cur_div = NEW_DIV;
		check_reg_read("DIV", `UART_ADDR_DIV, 16'(NEW_DIV));
		test_receive(2);
		test_transmit(2);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		rx_line = 1'b1;
		reg_write = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		tx_valid = 1'b0;
		tx_data = '0;
		credit_return = 1'b0;
		reset = 1'b1;
		cur_div = `UART_RESET_DIV;
		lfsr = 32'h0e0d3faa;
		rx_rd = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		test_receive(3);
		test_credit_gating();
		test_overrun();
		test_framing_error();
		test_transmit(2);
		test_divisor_change();
		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_TIME);
		$display("Timeout, the tests did not finish in the expected time");
		abort_run();
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_cfg_if.sv
rtl/uart_baud_gen.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_regs.sv
rtl/uart_rx_credit.sv
rtl/uart_top.sv
verification/uart_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the UART testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

LOG=sim.log

verilator --binary --timing -f compile.f --top-module uart_tb -o uart_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/uart_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

grep -q "ALL CHECKS PASSED" "$LOG"
if [ $? -ne 0 ]; then
	echo "Pass message not found in $LOG"
	exit 1
fi
exit 0
